/* sim/controller_stimulus.txt */
# tid attr addr len wdata | exp_err exp_len exp_rdata (all hex)
# attr 1 write, 2 read; err 0 none, 1 bad cmd, 2 bad len, 3 addr nack
1 1 5A 1 0037 0 1 0000
2 1 5A 2 BEEF 0 2 0000
3 2 5A 1 0000 0 1 00A0
4 2 5A 2 0000 0 2 A1A0
5 1 33 1 1234 3 0 0000
6 2 11 2 0000 3 0 0000
7 5 5A 1 0000 1 0 0000
8 1 5A 0 0000 2 0 0000
9 2 5A 3 0000 2 0 0000
A 0 5A 3 0000 1 0 0000
B 1 5A 2 C35A 0 2 0000
C 2 5A 2 0000 0 2 A1A0

/* build.f */
+incdir+source
source/hci_pkg.sv
source/bus_pkg.sv
source/hci_queue.sv
source/cmd_decoder.sv
source/bus_engine.sv
source/resp_builder.sv
source/controller.sv
sim/i2c_target_model.sv
sim/controller_assertions.sv
sim/controller_tb.sv

/* Bender.yml */
package:
  name: i3c_i2c_controller

sources:
  - include_dirs:
      - source
    files:
      - source/hci_pkg.sv
      - source/bus_pkg.sv
      - source/hci_queue.sv
      - source/cmd_decoder.sv
      - source/bus_engine.sv
      - source/resp_builder.sv
      - source/controller.sv
  - target: simulation
    files:
      - sim/i2c_target_model.sv
      - sim/controller_assertions.sv
      - sim/controller_tb.sv

/* sim/controller_tb.sv */
// Testbench for the I2C-mode controller
// Reads commands from a stimulus file, checks responses and target captures
`timescale 1ns/1ps
`default_nettype none

module controller_tb;
    logic        clk_i;
    logic        rst_i;
    logic        phy_en_i;
    logic        cmd_valid_i;
    logic        cmd_ready_o;
    logic [63:0] cmd_data_i;
    logic        resp_valid_o;
    logic        resp_ready_i;
    logic [31:0] resp_data_o;
    logic        dut_scl;
    logic        dut_sda;
    logic        tgt_sda;
    logic        i3c_fsm_idle_o;
    wire         scl_line = dut_scl;
    wire         sda_line = dut_sda & tgt_sda;

    integer seed = 32'he370;
    int     errors = 0;
    int     num_cmds = 0;
    logic   scl_moved = 1'b0;
    logic   went_busy = 1'b0;
    logic [15:0] st_fields [0:31][0:7];

    controller dut0 (
        .clk_i(clk_i), .rst_i(rst_i), .phy_en_i(phy_en_i),
        .cmd_valid_i(cmd_valid_i), .cmd_ready_o(cmd_ready_o), .cmd_data_i(cmd_data_i),
        .resp_valid_o(resp_valid_o), .resp_ready_i(resp_ready_i),
        .resp_data_o(resp_data_o),
        .scl_i(scl_line), .sda_i(sda_line), .scl_o(dut_scl), .sda_o(dut_sda),
        .i3c_fsm_idle_o(i3c_fsm_idle_o)
    );

    i2c_target_model tgt0 (.scl_i(scl_line), .sda_i(sda_line), .sda_o(tgt_sda));

    bind controller controller_assertions asrt0 (.*);

    always #4 clk_i = ~clk_i;

    // Random back-pressure on the response queue
    always @(posedge clk_i) begin
        if (!rst_i) begin
            resp_ready_i <= ($random(seed) & 3) != 0;
        end
    end

    // Bus and engine activity while one command is in flight
    always @(negedge clk_i) begin
        if (!dut_scl) begin
            scl_moved <= 1'b1;
        end
        if (!i3c_fsm_idle_o) begin
            went_busy <= 1'b1;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Errors: %0d", errors + 1);
        $display("Test failed");
        $finish;
    endtask

    task automatic load_stimulus();
        integer fd;
        integer n;
        string  line;
        logic [15:0] f [0:7];
        fd = $fopen("sim/controller_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the stimulus file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                    if (n == 8) begin
                        for (int i = 0; i < 8; i++) begin
                            st_fields[num_cmds][i] = f[i];
                        end
                        num_cmds++;
                    end
                end
            end
            $fclose(fd);
            if (num_cmds == 0) begin
                abort_run("The stimulus file holds no commands");
            end
        end
    endtask

    task automatic send_command(input int idx);
        hci_pkg::cmd_desc_t d;
        int t;
        d = '0;
        d.tid      = st_fields[idx][0][3:0];
        d.cmd_attr = st_fields[idx][1][2:0];
        d.dev_addr = st_fields[idx][2][6:0];
        d.data_len = st_fields[idx][3][2:0];
        d.wdata    = st_fields[idx][4];
        @(posedge clk_i);
        cmd_valid_i <= 1'b1;
        cmd_data_i  <= d;
        t = 0;
        do begin
            @(negedge clk_i);
            t++;
            if (t > 1000) begin
                abort_run($sformatf("Timeout: command %0d was never accepted", idx));
            end
        end while (!cmd_ready_o);
        @(posedge clk_i);
        cmd_valid_i <= 1'b0;
    endtask

    task automatic receive_response(output hci_pkg::resp_desc_t r, input int idx);
        int t;
        t = 0;
        do begin
            @(negedge clk_i);
            t++;
            if (t > 5000) begin
                abort_run($sformatf("Timeout: no response arrived for command %0d", idx));
            end
        end while (!(resp_valid_o && resp_ready_i));
        r = resp_data_o;
        @(posedge clk_i);
    endtask

    task automatic check_response(input hci_pkg::resp_desc_t r, input int idx);
        check_value("resp tid", r.tid, st_fields[idx][0]);
        check_value("resp err_status", r.err_status, st_fields[idx][5]);
        check_value("resp data_len", r.data_len, st_fields[idx][6]);
        check_value("resp rdata", r.rdata, st_fields[idx][7]);
    endtask

    // Bytes of a successful write land in the target low byte first
    task automatic check_captures(input int idx, inout int ptr);
        int n;
        n = (st_fields[idx][1] == 16'h1 && st_fields[idx][5] == 16'h0) ?
            int'(st_fields[idx][3]) : 0;
        for (int k = 0; k < n; k++) begin
            check_value("captured byte", tgt0.cap_bytes[ptr + k],
                        st_fields[idx][4] >> (8 * k) & 16'hff);
        end
        ptr += n;
    endtask

    initial begin
        hci_pkg::resp_desc_t r;
        int   cap_ptr;
        logic is_xfer;
        clk_i        = 1'b0;
        rst_i        = 1'b1;
        phy_en_i     = 1'b0;
        cmd_valid_i  = 1'b0;
        cmd_data_i   = '0;
        resp_ready_i = 1'b0;
        cap_ptr      = 0;
        load_stimulus();
        repeat (16) @(posedge clk_i);
        rst_i    <= 1'b0;
        phy_en_i <= 1'b1;
        // One command at a time
        for (int i = 0; i < num_cmds; i++) begin
            is_xfer = (st_fields[i][5] != 16'h1) && (st_fields[i][5] != 16'h2);
            scl_moved <= 1'b0;
            went_busy <= 1'b0;
            send_command(i);
            receive_response(r, i);
            check_response(r, i);
            // Decode errors must leave the bus alone
            check_value("scl_o activity", scl_moved, is_xfer);
            check_value("i3c_fsm_idle_o low seen", went_busy, is_xfer);
            check_value("i3c_fsm_idle_o", i3c_fsm_idle_o, 1);
            check_captures(i, cap_ptr);
            check_value("captured count", tgt0.cap_count, cap_ptr);
        end
        // Back-to-back commands fill the queues, responses keep command order
        fork
            for (int i = 0; i < num_cmds; i++) begin
                send_command(i);
            end
            for (int j = 0; j < num_cmds; j++) begin
                receive_response(r, j);
                check_response(r, j);
                check_captures(j, cap_ptr);
            end
        join
        check_value("captured count", tgt0.cap_count, cap_ptr);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/controller_assertions.sv */
// Concurrent checks on the controller top
// Queue handshake stability and released bus lines while idle
`timescale 1ns/1ps
`default_nettype none

module controller_assertions (
    input logic        clk_i,
    input logic        rst_i,
    input logic        cmd_valid_i,
    input logic        cmd_ready_o,
    input logic [63:0] cmd_data_i,
    input logic        resp_valid_o,
    input logic        resp_ready_i,
    input logic [31:0] resp_data_o,
    input logic        scl_o,
    input logic        sda_o,
    input logic        i3c_fsm_idle_o
);
    cmd_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        cmd_valid_i && !cmd_ready_o |=> $stable(cmd_data_i))
        else $error("command data changed while waiting for ready");

    resp_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_data_o))
        else $error("response changed while waiting for ready");

    idle_lines: assert property (@(posedge clk_i) disable iff (rst_i)
        i3c_fsm_idle_o |-> scl_o && sda_o)
        else $error("bus lines driven while engine idle");

endmodule

`default_nettype wire

/* sim/i2c_target_model.sv */
// Behavioral I2C target on the wired-AND bus
// Answers one address, records written bytes, serves 0xA0 + k on reads
`timescale 1ns/1ps
`default_nettype none

module i2c_target_model (
    input  logic scl_i,
    input  logic sda_i,
    output logic sda_o
);
    localparam logic [6:0] OwnAddr = 7'h5A;

    logic [7:0] cap_bytes [0:31];
    int         cap_count;
    logic       in_xfer;
    logic       addr_phase;
    logic       active;
    logic       reading;
    logic       nacked;
    logic [3:0] bit_idx;
    logic [7:0] shreg;
    logic [7:0] rd_byte;
    int         rd_idx;

    initial begin
        sda_o     = 1'b1;
        cap_count = 0;
        in_xfer   = 1'b0;
    end

    // START and STOP
    always @(negedge sda_i) begin
        if (scl_i) begin
            in_xfer    = 1'b1;
            addr_phase = 1'b1;
            active     = 1'b0;
            reading    = 1'b0;
            nacked     = 1'b0;
            bit_idx    = '0;
            rd_idx     = 0;
            sda_o      = 1'b1;
        end
    end

    always @(posedge sda_i) begin
        if (scl_i) begin
            in_xfer = 1'b0;
            sda_o   = 1'b1;
        end
    end

    // Sample on the rising SCL edge
    always @(posedge scl_i) begin
        if (in_xfer) begin
            if (bit_idx < 4'd8) begin
                shreg = {shreg[6:0], sda_i};
                if (bit_idx == 4'd7) begin
                    if (addr_phase) begin
                        active  = (shreg[7:1] == OwnAddr);
                        reading = shreg[0];
                    end else if (active && !reading) begin
                        cap_bytes[cap_count] = shreg;
                        cap_count++;
                    end
                end
            end else begin
                if (reading && !addr_phase && sda_i) begin
                    nacked = 1'b1;
                end
                if (addr_phase) begin
                    addr_phase = 1'b0;
                end else if (reading) begin
                    rd_idx++;
                end
            end
            bit_idx = (bit_idx == 4'd8) ? 4'd0 : bit_idx + 4'd1;
        end
    end

    // Drive while SCL is low
    always @(negedge scl_i) begin
        if (in_xfer) begin
            rd_byte = 8'hA0 + rd_idx[7:0];
            if (bit_idx == 4'd8) begin
                sda_o = ~(active && (addr_phase || !reading));
            end else if (active && reading && !addr_phase && !nacked) begin
                sda_o = rd_byte[3'd7 - bit_idx[2:0]];
            end else begin
                sda_o = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/controller.sv */
// I2C-mode active controller top
// Command and response queues around decoder, bus engine and response builder
`timescale 1ns/1ps
`default_nettype none

module controller (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        phy_en_i,
    input  logic        cmd_valid_i,
    output logic        cmd_ready_o,
    input  logic [63:0] cmd_data_i,
    output logic        resp_valid_o,
    input  logic        resp_ready_i,
    output logic [31:0] resp_data_o,
    input  logic        scl_i,
    input  logic        sda_i,
    output logic        scl_o,
    output logic        sda_o,
    output logic        i3c_fsm_idle_o
);
    logic                cmd_full;
    logic                cmd_q_valid;
    logic                cmd_q_ready;
    hci_pkg::cmd_desc_t  cmd_q_data;
    logic                resp_almost_full;
    logic                resp_room;
    logic                xfer_start;
    logic                engine_busy;
    bus_pkg::xfer_req_t  xfer_req;
    logic                dec_err_valid;
    logic [3:0]          dec_err_tid;
    hci_pkg::err_code_t  dec_err_code;
    logic                xfer_done;
    logic [3:0]          done_tid;
    hci_pkg::err_code_t  done_code;
    logic [1:0]          done_len;
    logic [15:0]         done_rdata;
    logic                resp_push;
    hci_pkg::resp_desc_t resp_push_data;

    assign cmd_ready_o    = ~cmd_full;
    assign resp_room      = ~resp_almost_full;
    assign i3c_fsm_idle_o = ~engine_busy;

    hci_queue #(.payload_t(hci_pkg::cmd_desc_t)) xcmd_queue (
        .clk_i(clk_i), .rst_i(rst_i),
        .push_i(cmd_valid_i), .push_data_i(cmd_data_i),
        .full_o(cmd_full), .almost_full_o(),
        .valid_o(cmd_q_valid), .ready_i(cmd_q_ready), .data_o(cmd_q_data)
    );

    cmd_decoder xcmd_decoder (
        .clk_i(clk_i), .rst_i(rst_i), .phy_en_i(phy_en_i),
        .cmd_valid_i(cmd_q_valid), .cmd_ready_o(cmd_q_ready), .cmd_data_i(cmd_q_data),
        .resp_room_i(resp_room), .engine_busy_i(engine_busy),
        .xfer_start_o(xfer_start), .xfer_req_o(xfer_req),
        .dec_err_valid_o(dec_err_valid), .dec_err_tid_o(dec_err_tid),
        .dec_err_code_o(dec_err_code)
    );

    bus_engine xbus_engine (
        .clk_i(clk_i), .rst_i(rst_i),
        .xfer_start_i(xfer_start), .xfer_req_i(xfer_req), .busy_o(engine_busy),
        .scl_i(scl_i), .sda_i(sda_i), .scl_o(scl_o), .sda_o(sda_o),
        .xfer_done_o(xfer_done), .done_tid_o(done_tid), .done_code_o(done_code),
        .done_len_o(done_len), .done_rdata_o(done_rdata)
    );

    resp_builder xresp_builder (
        .clk_i(clk_i), .rst_i(rst_i),
        .dec_err_valid_i(dec_err_valid), .dec_err_tid_i(dec_err_tid),
        .dec_err_code_i(dec_err_code),
        .xfer_done_i(xfer_done), .done_tid_i(done_tid), .done_code_i(done_code),
        .done_len_i(done_len), .done_rdata_i(done_rdata),
        .push_o(resp_push), .push_data_o(resp_push_data)
    );

    // Response queue, never full thanks to the room check in the decoder
    hci_queue #(.payload_t(hci_pkg::resp_desc_t)) xresp_queue (
        .clk_i(clk_i), .rst_i(rst_i),
        .push_i(resp_push), .push_data_i(resp_push_data),
        .full_o(), .almost_full_o(resp_almost_full),
        .valid_o(resp_valid_o), .ready_i(resp_ready_i), .data_o(resp_data_o)
    );

endmodule

`default_nettype wire

/* source/resp_builder.sv */
// Response descriptor builder
// One response per decode error or finished bus transfer
`timescale 1ns/1ps
`default_nettype none

module resp_builder (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                dec_err_valid_i,
    input  logic [3:0]          dec_err_tid_i,
    input  hci_pkg::err_code_t  dec_err_code_i,
    input  logic                xfer_done_i,
    input  logic [3:0]          done_tid_i,
    input  hci_pkg::err_code_t  done_code_i,
    input  logic [1:0]          done_len_i,
    input  logic [15:0]         done_rdata_i,
    output logic                push_o,
    output hci_pkg::resp_desc_t push_data_o
);
    hci_pkg::resp_desc_t desc;

    // Decode errors carry no data
    always_comb begin
        desc.err_status = done_code_i;
        desc.tid        = done_tid_i;
        desc.data_len   = {6'd0, done_len_i};
        desc.rdata      = done_rdata_i;
        if (dec_err_valid_i) begin
            desc.err_status = dec_err_code_i;
            desc.tid        = dec_err_tid_i;
            desc.data_len   = '0;
            desc.rdata      = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            push_o <= 1'b0;
        end else begin
            push_o <= dec_err_valid_i | xfer_done_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (dec_err_valid_i | xfer_done_i) begin
            push_data_o <= desc;
        end
    end

endmodule

`default_nettype wire

/* source/bus_engine.sv */
// Open-drain I2C master bit engine
// START, address with RnW, one or two data bytes, ACK/NACK and STOP
`timescale 1ns/1ps
`default_nettype none
`include "i3c_settings.svh"

module bus_engine (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               xfer_start_i,
    input  bus_pkg::xfer_req_t xfer_req_i,
    output logic               busy_o,
    input  logic               scl_i,
    input  logic               sda_i,
    output logic               scl_o,
    output logic               sda_o,
    output logic               xfer_done_o,
    output logic [3:0]         done_tid_o,
    output hci_pkg::err_code_t done_code_o,
    output logic [1:0]         done_len_o,
    output logic [15:0]        done_rdata_o
);
    localparam int Half = `I3C_SCL_HALF;
    localparam int CntW = (Half > 1) ? $clog2(Half) : 1;
    localparam logic [CntW-1:0] HalfLast = CntW'(Half - 1);
    localparam logic [CntW-1:0] StopRise = CntW'(Half / 2);

    bus_pkg::bus_phase_t phase_q;
    logic                half_q;
    logic [CntW-1:0]     cnt_q;
    logic [2:0]          bit_cnt_q;
    logic                byte_cnt_q;
    logic                sda_q;
    bus_pkg::xfer_req_t  req_q;
    logic [7:0]          shift_q;
    logic [15:0]         rdata_q;
    logic [1:0]          len_q;
    hci_pkg::err_code_t  code_q;

    logic start_ok;
    logic stall;
    logic tick;
    logic slot_end;
    logic last_byte;
    logic sda_next;

    assign busy_o   = (phase_q != bus_pkg::IDLE);
    assign start_ok = ~busy_o & xfer_start_i;
    // START holds until both lines read released
    assign stall     = (phase_q == bus_pkg::START) & ~half_q & ~(scl_i & sda_i);
    assign tick      = busy_o & ~stall & (cnt_q == HalfLast);
    assign slot_end  = tick & half_q;
    assign last_byte = byte_cnt_q | (req_q.data_len == 2'd1);

    // Each bit slot is an SCL low half then a high half
    assign scl_o = (phase_q == bus_pkg::IDLE) | (phase_q == bus_pkg::START) | half_q;
    // SDA trails SCL by one clock
    assign sda_o = sda_q;

    always_comb begin
        case (phase_q)
            bus_pkg::START: sda_next = ~half_q;
            bus_pkg::ADDR:  sda_next = shift_q[7];
            bus_pkg::DATA:  sda_next = req_q.rnw | shift_q[7];
            // Master ACK on reads, NACK after the last byte
            bus_pkg::DACK:  sda_next = ~req_q.rnw | last_byte;
            bus_pkg::STOP:  sda_next = half_q & (cnt_q >= StopRise);
            default:        sda_next = 1'b1;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            phase_q     <= bus_pkg::IDLE;
            half_q      <= 1'b0;
            cnt_q       <= '0;
            bit_cnt_q   <= '0;
            byte_cnt_q  <= 1'b0;
            sda_q       <= 1'b1;
            xfer_done_o <= 1'b0;
        end else begin
            sda_q       <= sda_next;
            xfer_done_o <= 1'b0;
            if (start_ok) begin
                phase_q    <= bus_pkg::START;
                half_q     <= 1'b0;
                cnt_q      <= '0;
                bit_cnt_q  <= '0;
                byte_cnt_q <= 1'b0;
            end else if (stall) begin
                cnt_q <= '0;
            end else if (tick) begin
                cnt_q  <= '0;
                half_q <= ~half_q;
                if (half_q) begin
                    case (phase_q)
                        bus_pkg::START: phase_q <= bus_pkg::ADDR;
                        bus_pkg::ADDR: begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                            if (bit_cnt_q == 3'd7) begin
                                phase_q <= bus_pkg::ACK;
                            end
                        end
                        bus_pkg::ACK: phase_q <= sda_i ? bus_pkg::STOP : bus_pkg::DATA;
                        bus_pkg::DATA: begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                            if (bit_cnt_q == 3'd7) begin
                                phase_q <= bus_pkg::DACK;
                            end
                        end
                        bus_pkg::DACK: begin
                            if ((!req_q.rnw && sda_i) || last_byte) begin
                                phase_q <= bus_pkg::STOP;
                            end else begin
                                phase_q    <= bus_pkg::DATA;
                                byte_cnt_q <= 1'b1;
                            end
                        end
                        bus_pkg::STOP: begin
                            phase_q     <= bus_pkg::IDLE;
                            xfer_done_o <= 1'b1;
                        end
                        default: phase_q <= bus_pkg::IDLE;
                    endcase
                end
            end else if (busy_o) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_ok) begin
            req_q   <= xfer_req_i;
            shift_q <= {xfer_req_i.dev_addr, xfer_req_i.rnw};
            rdata_q <= '0;
            len_q   <= '0;
            code_q  <= hci_pkg::ERR_NONE;
        end else if (slot_end) begin
            case (phase_q)
                bus_pkg::ADDR, bus_pkg::DATA: shift_q <= {shift_q[6:0], sda_i};
                bus_pkg::ACK: begin
                    shift_q <= req_q.wdata[7:0];
                    if (sda_i) begin
                        code_q <= hci_pkg::ERR_ADDR_NACK;
                    end
                end
                bus_pkg::DACK: begin
                    shift_q <= req_q.wdata[15:8];
                    if (req_q.rnw) begin
                        len_q <= len_q + 2'd1;
                        if (byte_cnt_q) begin
                            rdata_q[15:8] <= shift_q;
                        end else begin
                            rdata_q[7:0] <= shift_q;
                        end
                    end else if (sda_i) begin
                        code_q <= hci_pkg::ERR_DATA_NACK;
                    end else begin
                        len_q <= len_q + 2'd1;
                    end
                end
                default: shift_q <= shift_q;
            endcase
        end
    end

    assign done_tid_o   = req_q.tid;
    assign done_code_o  = code_q;
    assign done_len_o   = len_q;
    assign done_rdata_o = rdata_q;

endmodule

`default_nettype wire

/* source/cmd_decoder.sv */
// Command descriptor decoder
// Turns a legal command into a transfer request, anything else into an error event
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               phy_en_i,
    input  logic               cmd_valid_i,
    output logic               cmd_ready_o,
    input  hci_pkg::cmd_desc_t cmd_data_i,
    input  logic               resp_room_i,
    input  logic               engine_busy_i,
    output logic               xfer_start_o,
    output bus_pkg::xfer_req_t xfer_req_o,
    output logic               dec_err_valid_o,
    output logic [3:0]         dec_err_tid_o,
    output hci_pkg::err_code_t dec_err_code_o
);
    logic accept;
    logic is_read;
    logic attr_ok;
    logic len_ok;

    assign is_read = (cmd_data_i.cmd_attr == hci_pkg::CMD_ATTR_READ);
    assign attr_ok = is_read | (cmd_data_i.cmd_attr == hci_pkg::CMD_ATTR_WRITE);
    assign len_ok  = (cmd_data_i.data_len == 3'd1) | (cmd_data_i.data_len == 3'd2);

    // One command in flight, and only with response room and an idle engine
    assign cmd_ready_o = phy_en_i & resp_room_i & ~engine_busy_i &
                         ~xfer_start_o & ~dec_err_valid_o;
    assign accept = cmd_valid_i & cmd_ready_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            xfer_start_o    <= 1'b0;
            dec_err_valid_o <= 1'b0;
        end else begin
            xfer_start_o    <= accept & attr_ok & len_ok;
            dec_err_valid_o <= accept & ~(attr_ok & len_ok);
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            xfer_req_o.tid      <= cmd_data_i.tid;
            xfer_req_o.rnw      <= is_read;
            xfer_req_o.dev_addr <= cmd_data_i.dev_addr;
            xfer_req_o.data_len <= cmd_data_i.data_len[1:0];
            xfer_req_o.wdata    <= cmd_data_i.wdata;
            dec_err_tid_o       <= cmd_data_i.tid;
            // Bad attribute wins over bad length
            dec_err_code_o      <= attr_ok ? hci_pkg::ERR_BAD_LEN : hci_pkg::ERR_BAD_CMD;
        end
    end

endmodule

`default_nettype wire

/* source/hci_queue.sv */
// Synchronous FIFO with a type-parameter payload
// Circular buffer with full and almost-full levels
`timescale 1ns/1ps
`default_nettype none
`include "i3c_settings.svh"

module hci_queue #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     push_i,
    input  payload_t push_data_i,
    output logic     full_o,
    output logic     almost_full_o,
    output logic     valid_o,
    input  logic     ready_i,
    output payload_t data_o
);
    localparam int Depth = `I3C_QUEUE_DEPTH;
    localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam logic [PtrW:0] FullLevel = (PtrW + 1)'(Depth);
    localparam logic [PtrW:0] AlmostLevel = (PtrW + 1)'(Depth - 1);

    payload_t        mem [Depth];
    logic [PtrW-1:0] wr_ptr_q;
    logic [PtrW-1:0] rd_ptr_q;
    logic [PtrW:0]   count_q;
    logic            do_push;
    logic            do_pop;

    assign full_o        = (count_q == FullLevel);
    assign almost_full_o = (count_q >= AlmostLevel);
    assign valid_o       = (count_q != '0);
    assign data_o        = mem[rd_ptr_q];

    // A push into a full queue is dropped
    assign do_push = push_i & ~full_o;
    assign do_pop  = valid_o & ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

`default_nettype wire

/* source/bus_pkg.sv */
// Bus engine types
// Phase encoding and the transfer request passed from the decoder
`default_nettype none

package bus_pkg;

    typedef enum logic [2:0] {
        IDLE,
        START,
        ADDR,
        ACK,
        DATA,
        DACK,
        STOP
    } bus_phase_t;

    // data_len is 1 or 2, byte 0 of wdata in the low byte
    typedef struct packed {
        logic [3:0]  tid;
        logic        rnw;
        logic [6:0]  dev_addr;
        logic [1:0]  data_len;
        logic [15:0] wdata;
    } xfer_req_t;

endpackage

`default_nettype wire

/* source/hci_pkg.sv */
// Host interface descriptor types
// Command and response descriptors, command attributes and error codes
`default_nettype none

package hci_pkg;

    // Command attribute encodings
    localparam logic [2:0] CMD_ATTR_WRITE = 3'd1;
    localparam logic [2:0] CMD_ATTR_READ  = 3'd2;

    typedef enum logic [3:0] {
        ERR_NONE      = 4'h0,
        ERR_BAD_CMD   = 4'h1,
        ERR_BAD_LEN   = 4'h2,
        ERR_ADDR_NACK = 4'h3,
        ERR_DATA_NACK = 4'h4
    } err_code_t;

    // 64-bit command, tid in the low bits
    typedef struct packed {
        logic [15:0] wdata;
        logic [30:0] reserved;
        logic [2:0]  data_len;
        logic [6:0]  dev_addr;
        logic [2:0]  cmd_attr;
        logic [3:0]  tid;
    } cmd_desc_t;

    // 32-bit response
    typedef struct packed {
        err_code_t   err_status;
        logic [3:0]  tid;
        logic [7:0]  data_len;
        logic [15:0] rdata;
    } resp_desc_t;

endpackage

`default_nettype wire

/* source/i3c_settings.svh */
// Build-time settings for the I2C-mode controller
// Queue depth and SCL half period in clock cycles
`ifndef I3C_SETTINGS_SVH
`define I3C_SETTINGS_SVH

// Entries per command and response queue, power of two
`define I3C_QUEUE_DEPTH 4

// Clock cycles per SCL half period
`define I3C_SCL_HALF 4

`endif
